/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // first fetch after reset
  localparam word_t BOOT_ADDR = '0;

  // major opcodes, only the subset this core executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011
  } opcode_e;

  // funct3 codes for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 codes for BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // source of an EX operand
  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

`default_nettype wire

/* front_end/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           stall_i,
  input  logic           flush_i,
  input  logic           branch_taken_i,
  input  cpu_pkg::word_t branch_target_i,
  input  cpu_pkg::word_t instr_i,
  output cpu_pkg::word_t imem_addr_o,
  output cpu_pkg::word_t if_pc_o,
  output cpu_pkg::word_t if_instr_o,
  output logic           if_valid_o
);
  import cpu_pkg::*;

  word_t pc_q;

  assign imem_addr_o = pc_q;

  // branch redirect wins over a load-use hold
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (branch_taken_i) begin
      pc_q <= branch_target_i;
    end else if (!stall_i) begin
      pc_q <= pc_q + word_t'(4);
    end
  end

  // IF/ID
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_valid_o <= 1'b0;
    end else if (flush_i) begin
      if_valid_o <= 1'b0;
    end else if (!stall_i) begin
      if_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      if_pc_o    <= pc_q;
      if_instr_o <= instr_i;
    end
  end

endmodule

`default_nettype wire

/* front_end/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stall_i,
  input  logic               flush_i,
  input  cpu_pkg::word_t     if_pc_i,
  input  cpu_pkg::word_t     if_instr_i,
  input  logic               if_valid_i,
  input  cpu_pkg::word_t     rs1_data_i,
  input  cpu_pkg::word_t     rs2_data_i,
  output cpu_pkg::reg_addr_t rs1_addr_o,
  output cpu_pkg::reg_addr_t rs2_addr_o,
  output cpu_pkg::word_t     ex_pc_o,
  output cpu_pkg::word_t     ex_rs1_data_o,
  output cpu_pkg::word_t     ex_rs2_data_o,
  output cpu_pkg::word_t     ex_imm_o,
  output cpu_pkg::reg_addr_t ex_rs1_addr_o,
  output cpu_pkg::reg_addr_t ex_rs2_addr_o,
  output cpu_pkg::reg_addr_t ex_rd_addr_o,
  output cpu_pkg::alu_op_e   ex_alu_op_o,
  output logic               ex_use_imm_o,
  output logic               ex_regwrite_o,
  output logic               ex_mem_rd_o,
  output logic               ex_mem_wr_o,
  output logic               ex_branch_o,
  output logic               ex_branch_ne_o
);
  import cpu_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  alu_op_e    alu_op;
  word_t      imm;
  logic       use_imm;
  logic       regwrite;
  logic       mem_rd;
  logic       mem_wr;
  logic       branch;
  logic       uses_rs2;
  logic       bubble;

  function automatic alu_op_e alu_decode(logic [2:0] f3, logic sub);
    case (f3)
      F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
      F3_SLT:     return ALU_SLT;
      F3_XOR:     return ALU_XOR;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
      default:    return ALU_ADD;
    endcase
  endfunction

  assign opcode = opcode_e'(if_instr_i[6:0]);
  assign funct3 = if_instr_i[14:12];
  assign bubble = stall_i || flush_i || !if_valid_i;

  // unused sources read as x0 so they never cause a stall
  assign rs1_addr_o = if_valid_i ? if_instr_i[19:15] : '0;
  assign rs2_addr_o = (if_valid_i && uses_rs2) ? if_instr_i[24:20] : '0;

  always_comb begin
    alu_op   = ALU_ADD;
    imm      = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    use_imm  = 1'b0;
    regwrite = 1'b0;
    mem_rd   = 1'b0;
    mem_wr   = 1'b0;
    branch   = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OP: begin
        alu_op   = alu_decode(funct3, if_instr_i[30]);
        regwrite = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_IMM: begin
        alu_op   = alu_decode(funct3, 1'b0);
        use_imm  = 1'b1;
        regwrite = 1'b1;
      end
      LOAD: begin
        use_imm  = 1'b1;
        regwrite = 1'b1;
        mem_rd   = 1'b1;
      end
      STORE: begin
        imm      = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
        use_imm  = 1'b1;
        mem_wr   = 1'b1;
        uses_rs2 = 1'b1;
      end
      BRANCH: begin
        imm      = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
        branch   = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: ;
    endcase
  end

  // ID/EX enables, cleared to form a bubble
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_regwrite_o <= 1'b0;
      ex_mem_rd_o   <= 1'b0;
      ex_mem_wr_o   <= 1'b0;
      ex_branch_o   <= 1'b0;
    end else begin
      ex_regwrite_o <= regwrite && !bubble;
      ex_mem_rd_o   <= mem_rd && !bubble;
      ex_mem_wr_o   <= mem_wr && !bubble;
      ex_branch_o   <= branch && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc_o        <= if_pc_i;
    ex_rs1_data_o  <= rs1_data_i;
    ex_rs2_data_o  <= rs2_data_i;
    ex_imm_o       <= imm;
    ex_rs1_addr_o  <= rs1_addr_o;
    ex_rs2_addr_o  <= rs2_addr_o;
    ex_rd_addr_o   <= if_instr_i[11:7];
    ex_alu_op_o    <= alu_op;
    ex_use_imm_o   <= use_imm;
    ex_branch_ne_o <= (funct3 == F3_BNE);
  end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst_n_i,
  input  cpu_pkg::reg_addr_t rs1_addr_i,
  input  cpu_pkg::reg_addr_t rs2_addr_i,
  input  cpu_pkg::reg_addr_t rd_addr_i,
  input  cpu_pkg::word_t     rd_data_i,
  input  logic               rd_we_i,
  output cpu_pkg::word_t     rs1_data_o,
  output cpu_pkg::word_t     rs2_data_o
);
  import cpu_pkg::*;

  word_t regs [1:31];

  // x0 reads zero, a same-cycle write is bypassed to the reader
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (rd_we_i && (rd_addr_i == addr)) begin
      return rd_data_i;
    end
    return regs[addr];
  endfunction

  assign rs1_data_o = read_port(rs1_addr_i);
  assign rs2_data_o = read_port(rs2_addr_i);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

endmodule

`default_nettype wire

/* back_end/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  cpu_pkg::word_t     ex_pc_i,
  input  cpu_pkg::word_t     ex_rs1_data_i,
  input  cpu_pkg::word_t     ex_rs2_data_i,
  input  cpu_pkg::word_t     ex_imm_i,
  input  cpu_pkg::reg_addr_t ex_rd_addr_i,
  input  cpu_pkg::alu_op_e   ex_alu_op_i,
  input  logic               ex_use_imm_i,
  input  logic               ex_regwrite_i,
  input  logic               ex_mem_rd_i,
  input  logic               ex_mem_wr_i,
  input  logic               ex_branch_i,
  input  logic               ex_branch_ne_i,
  input  cpu_pkg::fwd_sel_e  fwd_a_i,
  input  cpu_pkg::fwd_sel_e  fwd_b_i,
  input  cpu_pkg::word_t     mem_fwd_data_i,
  input  cpu_pkg::word_t     wb_fwd_data_i,
  output logic               branch_taken_o,
  output cpu_pkg::word_t     branch_target_o,
  output cpu_pkg::word_t     mem_alu_result_o,
  output cpu_pkg::word_t     mem_store_data_o,
  output cpu_pkg::reg_addr_t mem_rd_addr_o,
  output logic               mem_regwrite_o,
  output logic               mem_rd_o,
  output logic               mem_wr_o
);
  import cpu_pkg::*;

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_result;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf, word_t mem, word_t wb);
    case (sel)
      FWD_MEM: return mem;
      FWD_WB:  return wb;
      default: return rf;
    endcase
  endfunction

  assign op_a    = fwd_mux(fwd_a_i, ex_rs1_data_i, mem_fwd_data_i, wb_fwd_data_i);
  assign rs2_val = fwd_mux(fwd_b_i, ex_rs2_data_i, mem_fwd_data_i, wb_fwd_data_i);
  assign op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;

  always_comb begin
    case (ex_alu_op_i)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_XOR: alu_result = op_a ^ op_b;
      ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
      default: alu_result = op_a + op_b;
    endcase
  end

  // BEQ taken on equal, BNE on not equal
  assign branch_taken_o  = ex_branch_i && ((op_a == rs2_val) != ex_branch_ne_i);
  assign branch_target_o = ex_pc_i + ex_imm_i;

  // EX/MEM
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_regwrite_o <= 1'b0;
      mem_rd_o       <= 1'b0;
      mem_wr_o       <= 1'b0;
    end else begin
      mem_regwrite_o <= ex_regwrite_i;
      mem_rd_o       <= ex_mem_rd_i;
      mem_wr_o       <= ex_mem_wr_i;
    end
  end

  always_ff @(posedge clk) begin
    mem_alu_result_o <= alu_result;
    mem_store_data_o <= rs2_val;
    mem_rd_addr_o    <= ex_rd_addr_i;
  end

endmodule

`default_nettype wire

/* back_end/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  cpu_pkg::word_t     mem_alu_result_i,
  input  cpu_pkg::word_t     mem_store_data_i,
  input  cpu_pkg::reg_addr_t mem_rd_addr_i,
  input  logic               mem_regwrite_i,
  input  logic               mem_rd_i,
  input  logic               mem_wr_i,
  input  cpu_pkg::word_t     dmem_rdata_i,
  output cpu_pkg::word_t     dmem_addr_o,
  output cpu_pkg::word_t     dmem_wdata_o,
  output logic               dmem_rd_o,
  output logic               dmem_wr_o,
  output cpu_pkg::word_t     mem_fwd_data_o,
  output cpu_pkg::reg_addr_t wb_rd_addr_o,
  output cpu_pkg::word_t     wb_data_o,
  output logic               wb_regwrite_o
);
  import cpu_pkg::*;

  word_t mem_result;

  // data memory answers in the same cycle
  assign dmem_addr_o  = mem_alu_result_i;
  assign dmem_wdata_o = mem_store_data_i;
  assign dmem_rd_o    = mem_rd_i;
  assign dmem_wr_o    = mem_wr_i;

  // a load in MEM never forwards, the load-use stall keeps it apart
  assign mem_fwd_data_o = mem_alu_result_i;

  assign mem_result = mem_rd_i ? dmem_rdata_i : mem_alu_result_i;

  // MEM/WB
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_regwrite_o <= 1'b0;
    end else begin
      wb_regwrite_o <= mem_regwrite_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_addr_o <= mem_rd_addr_i;
    wb_data_o    <= mem_result;
  end

endmodule

`default_nettype wire

/* verilog/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  cpu_pkg::reg_addr_t id_rs1_addr_i,
  input  cpu_pkg::reg_addr_t id_rs2_addr_i,
  input  cpu_pkg::reg_addr_t ex_rs1_addr_i,
  input  cpu_pkg::reg_addr_t ex_rs2_addr_i,
  input  cpu_pkg::reg_addr_t ex_rd_addr_i,
  input  logic               ex_mem_rd_i,
  input  cpu_pkg::reg_addr_t mem_rd_addr_i,
  input  logic               mem_regwrite_i,
  input  cpu_pkg::reg_addr_t wb_rd_addr_i,
  input  logic               wb_regwrite_i,
  input  logic               branch_taken_i,
  output logic               stall_o,
  output logic               flush_if_o,
  output logic               flush_id_o,
  output cpu_pkg::fwd_sel_e  fwd_a_o,
  output cpu_pkg::fwd_sel_e  fwd_b_o
);
  import cpu_pkg::*;

  logic load_use;

  // youngest producer first
  function automatic fwd_sel_e fwd_select(reg_addr_t src);
    if (src == '0) begin
      return FWD_RF;
    end
    if (mem_regwrite_i && (mem_rd_addr_i == src)) begin
      return FWD_MEM;
    end
    if (wb_regwrite_i && (wb_rd_addr_i == src)) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  assign fwd_a_o = fwd_select(ex_rs1_addr_i);
  assign fwd_b_o = fwd_select(ex_rs2_addr_i);

  assign load_use = ex_mem_rd_i && (ex_rd_addr_i != '0) &&
                    ((ex_rd_addr_i == id_rs1_addr_i) || (ex_rd_addr_i == id_rs2_addr_i));

  // squashed instructions need no stall
  assign stall_o    = load_use && !branch_taken_i;
  assign flush_if_o = branch_taken_i;
  assign flush_id_o = branch_taken_i;

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic           clk,
  input  logic           rst_n_i,
  input  cpu_pkg::word_t instr_i,
  input  cpu_pkg::word_t dmem_rdata_i,
  output cpu_pkg::word_t imem_addr_o,
  output cpu_pkg::word_t dmem_addr_o,
  output cpu_pkg::word_t dmem_wdata_o,
  output logic           dmem_rd_o,
  output logic           dmem_wr_o
);
  import cpu_pkg::*;

  word_t     if_pc, if_instr;
  logic      if_valid;
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  reg_addr_t ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
  alu_op_e   ex_alu_op;
  logic      ex_use_imm, ex_regwrite, ex_mem_rd, ex_mem_wr, ex_branch, ex_branch_ne;
  logic      branch_taken;
  word_t     branch_target;
  word_t     mem_alu_result, mem_store_data, mem_fwd_data;
  reg_addr_t mem_rd_addr;
  logic      mem_regwrite, mem_rd, mem_wr;
  reg_addr_t wb_rd_addr;
  word_t     wb_data;
  logic      wb_regwrite;
  logic      stall, flush_if, flush_id;
  fwd_sel_e  fwd_a, fwd_b;

  if_stage if_stage_i (
    .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .flush_i(flush_if),
    .branch_taken_i(branch_taken), .branch_target_i(branch_target), .instr_i(instr_i),
    .imem_addr_o(imem_addr_o), .if_pc_o(if_pc), .if_instr_o(if_instr),
    .if_valid_o(if_valid)
  );

  id_stage id_stage_i (
    .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall), .flush_i(flush_id),
    .if_pc_i(if_pc), .if_instr_i(if_instr), .if_valid_i(if_valid),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .ex_pc_o(ex_pc), .ex_rs1_data_o(ex_rs1_data), .ex_rs2_data_o(ex_rs2_data),
    .ex_imm_o(ex_imm), .ex_rs1_addr_o(ex_rs1_addr), .ex_rs2_addr_o(ex_rs2_addr),
    .ex_rd_addr_o(ex_rd_addr), .ex_alu_op_o(ex_alu_op), .ex_use_imm_o(ex_use_imm),
    .ex_regwrite_o(ex_regwrite), .ex_mem_rd_o(ex_mem_rd), .ex_mem_wr_o(ex_mem_wr),
    .ex_branch_o(ex_branch), .ex_branch_ne_o(ex_branch_ne)
  );

  reg_file reg_file_i (
    .clk(clk), .rst_n_i(rst_n_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rd_addr_i(wb_rd_addr), .rd_data_i(wb_data), .rd_we_i(wb_regwrite),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  ex_stage ex_stage_i (
    .clk(clk), .rst_n_i(rst_n_i),
    .ex_pc_i(ex_pc), .ex_rs1_data_i(ex_rs1_data), .ex_rs2_data_i(ex_rs2_data),
    .ex_imm_i(ex_imm), .ex_rd_addr_i(ex_rd_addr), .ex_alu_op_i(ex_alu_op),
    .ex_use_imm_i(ex_use_imm), .ex_regwrite_i(ex_regwrite), .ex_mem_rd_i(ex_mem_rd),
    .ex_mem_wr_i(ex_mem_wr), .ex_branch_i(ex_branch), .ex_branch_ne_i(ex_branch_ne),
    .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_data_i(mem_fwd_data), .wb_fwd_data_i(wb_data),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target),
    .mem_alu_result_o(mem_alu_result), .mem_store_data_o(mem_store_data),
    .mem_rd_addr_o(mem_rd_addr), .mem_regwrite_o(mem_regwrite),
    .mem_rd_o(mem_rd), .mem_wr_o(mem_wr)
  );

  mem_wb_stage mem_wb_stage_i (
    .clk(clk), .rst_n_i(rst_n_i),
    .mem_alu_result_i(mem_alu_result), .mem_store_data_i(mem_store_data),
    .mem_rd_addr_i(mem_rd_addr), .mem_regwrite_i(mem_regwrite),
    .mem_rd_i(mem_rd), .mem_wr_i(mem_wr), .dmem_rdata_i(dmem_rdata_i),
    .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
    .dmem_rd_o(dmem_rd_o), .dmem_wr_o(dmem_wr_o), .mem_fwd_data_o(mem_fwd_data),
    .wb_rd_addr_o(wb_rd_addr), .wb_data_o(wb_data), .wb_regwrite_o(wb_regwrite)
  );

  hazard_unit hazard_unit_i (
    .id_rs1_addr_i(rs1_addr), .id_rs2_addr_i(rs2_addr),
    .ex_rs1_addr_i(ex_rs1_addr), .ex_rs2_addr_i(ex_rs2_addr),
    .ex_rd_addr_i(ex_rd_addr), .ex_mem_rd_i(ex_mem_rd),
    .mem_rd_addr_i(mem_rd_addr), .mem_regwrite_i(mem_regwrite),
    .wb_rd_addr_i(wb_rd_addr), .wb_regwrite_i(wb_regwrite),
    .branch_taken_i(branch_taken), .stall_o(stall),
    .flush_if_o(flush_if), .flush_id_o(flush_id), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
  );

endmodule

`default_nettype wire

/* tb/cpu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
  input logic           clk,
  input logic           rst_n_i,
  input logic           dmem_rd_i,
  input logic           dmem_wr_i,
  input cpu_pkg::word_t dmem_addr_i
);

  // one data access per cycle
  rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(dmem_rd_i && dmem_wr_i))
    else $error("dmem read and write strobes high together");

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    (dmem_rd_i || dmem_wr_i) |-> (dmem_addr_i[1:0] == 2'b00))
    else $error("dmem address not word aligned");

  strobes_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown({dmem_rd_i, dmem_wr_i}))
    else $error("dmem strobes unknown");

endmodule

bind cpu_top cpu_asserts cpu_asserts_i (
  .clk(clk), .rst_n_i(rst_n_i), .dmem_rd_i(dmem_rd_o),
  .dmem_wr_i(dmem_wr_o), .dmem_addr_i(dmem_addr_o)
);

`default_nettype wire

/* tb/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam word_t NOP = 32'h0000_0013;

  logic  clk;
  logic  rst_n;
  word_t instr, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
  logic  dmem_rd, dmem_wr;

  word_t imem [256];
  word_t dmem [256];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    n_instr, err_count, check_count, n_seen;
  word_t rng;
  int    cycles, limit;
  logic  waiting;
  string test_name;

  cpu_top cpu_top_i (
    .clk(clk), .rst_n_i(rst_n), .instr_i(instr), .dmem_rdata_i(dmem_rdata),
    .imem_addr_o(imem_addr), .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
    .dmem_rd_o(dmem_rd), .dmem_wr_o(dmem_wr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // both memories answer in the same cycle
  assign instr      = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  function automatic word_t fill_word(int idx);
    return word_t'(idx) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t xorshift(word_t s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic word_t rand_next();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic word_t enc_s(int imm, int rs2, int rs1);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(int imm, int rs2, int rs1, logic [2:0] f3);
    logic [12:0] i;
    i = 13'(imm);
    return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
  endfunction

  function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA-level run of imem that collects the expected store sequence
  function automatic void run_model();
    word_t x [32];
    word_t mem [256];
    word_t pc, ins, a, b, imm, res, nxt, ea;
    logic  wr;
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
    pc = '0;
    for (int steps = 0; steps < 4096; steps++) begin
      ins = imem[pc[9:2]];
      a   = x[ins[19:15]];
      b   = x[ins[24:20]];
      imm = {{20{ins[31]}}, ins[31:20]};
      res = '0;
      wr  = 1'b0;
      nxt = pc + 32'd4;
      case (ins[6:0])
        7'b0110011: begin
          res = alu_ref(ins[14:12], ins[30], a, b);
          wr  = 1'b1;
        end
        7'b0010011: begin
          res = alu_ref(ins[14:12], 1'b0, a, imm);
          wr  = 1'b1;
        end
        7'b0000011: begin
          ea  = a + imm;
          res = mem[ea[9:2]];
          wr  = 1'b1;
        end
        7'b0100011: begin
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_addr.push_back(ea);
          exp_data.push_back(b);
          mem[ea[9:2]] = b;
        end
        7'b1100011: begin
          imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          if ((ins[14:12] == 3'b001) ? (a != b) : (a == b)) begin
            // self-loop marks the end of the program
            if (imm == '0) break;
            nxt = pc + imm;
          end
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
      pc = nxt;
    end
  endfunction

  task automatic check_word(string name, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_store(word_t addr, word_t data, word_t e_addr, word_t e_data);
    check_count++;
    if (addr !== e_addr || data !== e_data) begin
      $display("FAIL %0t: store %h <- %h, expected %h <- %h",
               $time, addr, data, e_addr, e_data);
      err_count++;
    end
  endtask

  // compare process that also performs the memory write
  always @(posedge clk) begin
    word_t ea;
    word_t ed;
    if (rst_n && dmem_wr) begin
      if (exp_addr.size() == 0) begin
        $display("unexpected store to %h at time %0t", dmem_addr, $time);
        err_count++;
      end else begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        check_store(dmem_addr, dmem_wdata, ea, ed);
        n_seen++;
      end
      dmem[dmem_addr[9:2]] = dmem_wdata;
    end
  end

  // cycle budget while expected stores are outstanding
  always @(posedge clk) begin
    if (waiting) begin
      cycles++;
      if (cycles > limit) begin
        $display("timeout in test %s: %0d expected stores never appeared",
                 test_name, exp_addr.size());
        $display("Verification failed");
        $finish;
      end
    end
  end

  task automatic emit(word_t w);
    imem[n_instr] = w;
    n_instr++;
  endtask

  task automatic new_program();
    n_instr = 0;
    for (int i = 0; i < 256; i++) imem[i] = NOP;
  endtask

  task automatic end_program();
    emit(enc_b(0, 0, 0, 3'b001));
    emit(enc_b(0, 0, 0, 3'b000));
  endtask

  task automatic apply_reset();
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
    @(negedge clk);
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic run_test(string name);
    int errs_before;
    errs_before = err_count;
    n_seen = 0;
    test_name = name;
    apply_reset();
    run_model();
    limit   = 4 * n_instr + 60;
    cycles  = 0;
    rst_n   = 1'b1;
    waiting = 1'b1;
    while (exp_addr.size() != 0) begin
      @(negedge clk);
    end
    waiting = 1'b0;
    // catch stores beyond the expected ones
    repeat (12) @(negedge clk);
    $display("test %s: %0d stores, %s", name, n_seen,
             (err_count == errs_before) ? "ok" : "mismatches");
  endtask

  task automatic alu_store(word_t ins, int addr);
    emit(ins);
    emit(enc_s(addr, 3, 0));
  endtask

  task automatic gen_random(int n);
    word_t r;
    int    rd, rs1, rs2;
    logic [2:0] f3s [5];
    f3s = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    new_program();
    for (int i = 1; i < 8; i++) emit(enc_i(int'(rand_next() % 4096), 0, 3'b000, i, 7'b0010011));
    for (int k = 0; k < n; k++) begin
      r   = rand_next();
      rd  = 1 + int'(r[10:8] % 7);
      rs1 = 1 + int'(r[13:11] % 7);
      rs2 = 1 + int'(r[16:14] % 7);
      case (r[1:0])
        2'd0: emit(enc_r(r[20] ? 7'b0100000 : 7'b0, rs2, rs1, r[20] ? 3'b000 : f3s[r[19:17] % 5],
                         rd));
        2'd1: emit(enc_i(int'(r[31:20]), rs1, f3s[r[19:17] % 5], rd, 7'b0010011));
        2'd2: emit(enc_i(4 * int'(r[6:2]), 0, 3'b010, rd, 7'b0000011));
        default: emit(enc_s(4 * int'(r[6:2]), rs2, 0));
      endcase
    end
    for (int i = 1; i < 8; i++) emit(enc_s(32'h80 + 4 * i, i, 0));
    end_program();
  endtask

  initial begin
    rst_n = 1'b0;
    waiting = 1'b0;
    cycles = 0;
    limit = 0;
    err_count = 0;
    check_count = 0;
    n_seen = 0;
    rng = 32'hcf9c;
    new_program();
    end_program();
    apply_reset();
    check_word("imem_addr_o", imem_addr, BOOT_ADDR);
    check_word("dmem_rd_o", word_t'(dmem_rd), '0);
    check_word("dmem_wr_o", word_t'(dmem_wr), '0);
    $display("test reset: %s", (err_count == 0) ? "ok" : "mismatches");

    new_program();
    emit(enc_i(123, 0, 3'b000, 1, 7'b0010011));
    emit(enc_i(-45, 0, 3'b000, 2, 7'b0010011));
    alu_store(enc_r(7'b0, 2, 1, 3'b000, 3), 0);
    alu_store(enc_r(7'b0100000, 2, 1, 3'b000, 3), 4);
    alu_store(enc_r(7'b0, 2, 1, 3'b111, 3), 8);
    alu_store(enc_r(7'b0, 2, 1, 3'b110, 3), 12);
    alu_store(enc_r(7'b0, 2, 1, 3'b100, 3), 16);
    alu_store(enc_r(7'b0, 1, 2, 3'b010, 3), 20);
    alu_store(enc_r(7'b0, 2, 1, 3'b010, 3), 24);
    alu_store(enc_i(-7, 1, 3'b000, 3, 7'b0010011), 28);
    alu_store(enc_i(12'h0f0, 2, 3'b111, 3, 7'b0010011), 32);
    alu_store(enc_i(12'h700, 1, 3'b110, 3, 7'b0010011), 36);
    alu_store(enc_i(-1, 1, 3'b100, 3, 7'b0010011), 40);
    alu_store(enc_i(-50, 2, 3'b010, 3, 7'b0010011), 44);
    end_program();
    run_test("alu");

    new_program();
    emit(enc_i(5, 0, 3'b000, 1, 7'b0010011));
    emit(enc_r(7'b0, 1, 1, 3'b000, 2));
    emit(enc_r(7'b0100000, 1, 2, 3'b000, 4));
    emit(enc_r(7'b0, 2, 1, 3'b100, 5));
    emit(enc_i(-1, 1, 3'b000, 6, 7'b0010011));
    emit(enc_s(32'h8c, 6, 0));
    emit(enc_s(32'h80, 2, 0));
    emit(enc_s(32'h84, 4, 0));
    emit(enc_s(32'h88, 5, 0));
    end_program();
    run_test("forwarding");

    new_program();
    emit(enc_i(32'h20, 0, 3'b010, 3, 7'b0000011));
    emit(enc_r(7'b0, 3, 3, 3'b000, 4));
    emit(enc_s(32'h24, 4, 0));
    emit(enc_i(77, 0, 3'b000, 1, 7'b0010011));
    emit(enc_s(32'h28, 1, 0));
    emit(enc_i(32'h28, 0, 3'b010, 5, 7'b0000011));
    emit(enc_r(7'b0, 1, 5, 3'b000, 6));
    emit(enc_s(32'h2c, 6, 0));
    end_program();
    run_test("load_use");

    new_program();
    emit(enc_i(7, 0, 3'b000, 1, 7'b0010011));
    emit(enc_i(7, 0, 3'b000, 2, 7'b0010011));
    emit(enc_b(8, 2, 1, 3'b000));
    emit(enc_s(32'h40, 1, 0));
    emit(enc_b(12, 0, 1, 3'b001));
    emit(enc_s(32'h44, 1, 0));
    emit(enc_s(32'h48, 1, 0));
    emit(enc_b(8, 0, 1, 3'b000));
    emit(enc_s(32'h4c, 2, 0));
    emit(enc_b(8, 2, 1, 3'b001));
    emit(enc_i(1, 1, 3'b000, 3, 7'b0010011));
    emit(enc_s(32'h50, 3, 0));
    end_program();
    run_test("branches");

    for (int t = 0; t < 3; t++) begin
      gen_random(40);
      run_test("random");
    end

    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
common/cpu_pkg.sv
front_end/if_stage.sv
front_end/id_stage.sv
verilog/reg_file.sv
back_end/ex_stage.sv
back_end/mem_wb_stage.sv
verilog/hazard_unit.sv
verilog/cpu_top.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
